// File: hw/axil_pkg.sv
package axil_pkg;

  // byte address width of the shared port
  localparam int ADDR_W = 16;

  // data bus width
  localparam int DATA_W = 32;

  // one strobe per data byte
  localparam int STRB_W = DATA_W / 8;

  // request kind carried on the request channel
  typedef enum logic [0:0] {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } axil_op_e;

  // request channel payload, 53 bits
  // read and write share this one channel
  typedef struct packed {
    // read or write
    axil_op_e            op;
    // byte address, the low bits select a byte within the word
    logic [ADDR_W-1:0]   addr;
    // write data, don't care for reads
    logic [DATA_W-1:0]   wdata;
    // byte enables for writes
    logic [STRB_W-1:0]   wstrb;
  } axil_req_t;

  // response channel payload, 33 bits
  typedef struct packed {
    // read data, zero for writes and for errors
    logic [DATA_W-1:0]   rdata;
    // set when the address is outside the subordinate
    logic                err;
  } axil_resp_t;

endpackage

// File: hw/sync_fifo.sv
module sync_fifo #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_SIZE  = 3
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // write side
  input  logic                  w_inc,
  input  logic [DATA_WIDTH-1:0] w_data,
  output logic                  w_almost_full,
  output logic                  w_full,

  // read side, r_data shows the head entry while not empty
  input  logic                  r_inc,
  output logic [DATA_WIDTH-1:0] r_data,
  output logic                  r_empty
);

  localparam int DEPTH = 1 << ADDR_SIZE;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // pointers carry one extra wrap bit so full and empty differ
  logic [ADDR_SIZE:0] w_ptr;
  logic [ADDR_SIZE:0] r_ptr;
  logic [ADDR_SIZE:0] fill;
  logic               w_en;
  logic               r_en;

  // entries held, from the pointer difference
  assign fill          = w_ptr - r_ptr;
  assign w_full        = fill == (ADDR_SIZE + 1)'(DEPTH);
  assign w_almost_full = fill >= (ADDR_SIZE + 1)'(DEPTH - 1);
  assign r_empty       = fill == '0;

  // overflow and underflow requests are ignored
  assign w_en = w_inc && !w_full;
  assign r_en = r_inc && !r_empty;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_ptr <= '0;
      r_ptr <= '0;
    end else begin
      if (w_en) w_ptr <= w_ptr + 1'b1;
      if (r_en) r_ptr <= r_ptr + 1'b1;
    end
  end

  // storage itself
  always_ff @(posedge clk) begin
    if (w_en) mem[w_ptr[ADDR_SIZE-1:0]] <= w_data;
  end

  // first word fall through
  assign r_data = mem[r_ptr[ADDR_SIZE-1:0]];

endmodule

// File: hw/axi_arbiter.sv
// fixed priority grant of the shared request channel with manager 0 highest
// response grants replay the order in which requests were accepted
module axi_arbiter
  import axil_pkg::*;
#(
  parameter  int NUM_M  = 3,
  localparam int G_BITS = $clog2(NUM_M + 1)
) (
  input  logic              axi_clk,
  input  logic              axi_resetn,

  // one bit per manager with a pending request
  input  logic [NUM_M-1:0]  g_want,

  // request and response handshakes seen on the subordinate side
  input  logic              req_accepted,
  input  logic              resp_accepted,

  // manager holding the request channel or NUM_M when nobody does
  output logic [G_BITS-1:0] g_req,
  // manager owed the next response or NUM_M when nothing is pending
  output logic [G_BITS-1:0] g_resp
);

  // 8 entries is far more than the transactions that can be in flight
  localparam int FIFO_ADDR = 3;

  logic [G_BITS-1:0] next_g_req;
  logic              holder_wants;
  logic [G_BITS-1:0] fifo_r_data;
  logic              fifo_r_empty;

  // does the current holder still drive valid
  // stays low while idle since NUM_M matches no manager index
  always_comb begin
    holder_wants = 1'b0;
    for (int i = 0; i < NUM_M; i++) begin
      if (g_req == G_BITS'(i)) holder_wants = g_want[i];
    end
  end

  always_comb begin
    next_g_req = G_BITS'(NUM_M);
    if (!req_accepted && holder_wants) begin
      // hold until the subordinate takes the request
      next_g_req = g_req;
    end else begin
      // lowest index wins so the downward scan lets it overwrite
      // the just accepted manager may win again while it still wants
      // a stale re-grant is let go the cycle its valid drops
      for (int i = NUM_M - 1; i >= 0; i--) begin
        if (g_want[i]) next_g_req = G_BITS'(i);
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      g_req <= G_BITS'(NUM_M);
    end else begin
      g_req <= next_g_req;
    end
  end

  // queue the holder on acceptance so each entry matches a real request
  // the entry lands one cycle after the grant at the earliest
  sync_fifo #(
    .DATA_WIDTH(G_BITS),
    .ADDR_SIZE (FIFO_ADDR)
  ) resp_fifo (
    .clk          (axi_clk),
    .rst_n        (axi_resetn),
    .w_inc        (req_accepted),
    .w_data       (g_req),
    .w_almost_full(),
    .w_full       (),
    .r_inc        (resp_accepted),
    .r_data       (fifo_r_data),
    .r_empty      (fifo_r_empty)
  );

  // head of the queue owns the response channel
  assign g_resp = fifo_r_empty ? G_BITS'(NUM_M) : fifo_r_data;

endmodule

// File: hw/axil_port_mux.sv
// steering between the managers and the single subordinate
// the arbiter decides, this block only routes
module axil_port_mux
  import axil_pkg::*;
#(
  parameter  int NUM_M  = 3,
  localparam int G_BITS = $clog2(NUM_M + 1)
) (
  // grants from the arbiter
  input  logic [G_BITS-1:0]            g_req,
  input  logic [G_BITS-1:0]            g_resp,

  // manager side
  input  axil_req_t  [NUM_M-1:0]       m_req,
  input  logic       [NUM_M-1:0]       m_req_valid,
  output logic       [NUM_M-1:0]       m_req_ready,
  output axil_resp_t [NUM_M-1:0]       m_resp,
  output logic       [NUM_M-1:0]       m_resp_valid,
  input  logic       [NUM_M-1:0]       m_resp_ready,

  // subordinate side
  output axil_req_t                    s_req,
  output logic                         s_req_valid,
  input  logic                         s_req_ready,
  input  axil_resp_t                   s_resp,
  input  logic                         s_resp_valid,
  output logic                         s_resp_ready
);

  // request channel
  // a grant of NUM_M matches no index, so the port stays quiet
  always_comb begin
    s_req       = '0;
    s_req_valid = 1'b0;
    m_req_ready = '0;
    for (int i = 0; i < NUM_M; i++) begin
      if (g_req == G_BITS'(i)) begin
        s_req          = m_req[i];
        s_req_valid    = m_req_valid[i];
        // ready only reaches the holder
        m_req_ready[i] = s_req_ready;
      end
    end
  end

  // response payload goes to every manager
  // only the valid is steered
  always_comb begin
    for (int i = 0; i < NUM_M; i++) begin
      m_resp[i] = s_resp;
    end
  end

  // response channel handshake
  always_comb begin
    m_resp_valid = '0;
    s_resp_ready = 1'b0;
    for (int i = 0; i < NUM_M; i++) begin
      if (g_resp == G_BITS'(i)) begin
        m_resp_valid[i] = s_resp_valid;
        // the owner's ready drains the subordinate's slot
        s_resp_ready    = m_resp_ready[i];
      end
    end
  end

endmodule

// File: hw/axil_mem.sv
// word memory behind the shared port
// request stage then response slot, one cycle from acceptance to response
module axil_mem
  import axil_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic       axi_clk,
  input  logic       axi_resetn,

  input  axil_req_t  s_req,
  input  logic       s_req_valid,
  output logic       s_req_ready,

  output axil_resp_t s_resp,
  output logic       s_resp_valid,
  input  logic       s_resp_ready
);

  // byte offset bits within a word
  localparam int LSB    = $clog2(STRB_W);
  localparam int WORD_W = $clog2(MEM_WORDS);

  logic [DATA_W-1:0] mem [MEM_WORDS];

  axil_req_t         stage_req;
  logic              stage_v;
  logic              slot_free;
  logic              advance;
  logic              in_range;
  logic [WORD_W-1:0] widx;
  axil_resp_t        resp_next;

  // slot can take a new response when empty or being drained now
  assign slot_free   = !s_resp_valid || s_resp_ready;
  assign s_req_ready = !stage_v || slot_free;
  assign advance     = stage_v && slot_free;

  // word index is addr / 4
  assign in_range = stage_req.addr[ADDR_W-1:LSB] < (ADDR_W - LSB)'(MEM_WORDS);
  assign widx     = stage_req.addr[LSB +: WORD_W];

  // writes answer with zero data
  always_comb begin
    resp_next.err   = !in_range;
    resp_next.rdata = '0;
    if (in_range && stage_req.op == OP_READ) resp_next.rdata = mem[widx];
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      stage_v      <= 1'b0;
      s_resp_valid <= 1'b0;
    end else begin
      if (s_req_ready) stage_v <= s_req_valid;
      if (slot_free) s_resp_valid <= stage_v;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (s_req_valid && s_req_ready) stage_req <= s_req;
    if (advance) begin
      s_resp <= resp_next;
      // out of range writes are dropped, strobed bytes only
      if (in_range && stage_req.op == OP_WRITE) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (stage_req.wstrb[b]) mem[widx][8*b +: 8] <= stage_req.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: hw/axil_shared_port.sv
// several AXI-Lite managers sharing one word memory
module axil_shared_port
  import axil_pkg::*;
#(
  parameter  int NUM_M     = 3,
  parameter  int MEM_WORDS = 256,
  localparam int G_BITS    = $clog2(NUM_M + 1)
) (
  input  logic                   axi_clk,
  input  logic                   axi_resetn,

  // one lane per manager
  input  axil_req_t  [NUM_M-1:0] m_req,
  input  logic       [NUM_M-1:0] m_req_valid,
  output logic       [NUM_M-1:0] m_req_ready,
  output axil_resp_t [NUM_M-1:0] m_resp,
  output logic       [NUM_M-1:0] m_resp_valid,
  input  logic       [NUM_M-1:0] m_resp_ready
);

  // subordinate side of the mux
  axil_req_t         s_req;
  logic              s_req_valid;
  logic              s_req_ready;
  axil_resp_t        s_resp;
  logic              s_resp_valid;
  logic              s_resp_ready;

  // grants
  logic [G_BITS-1:0] g_req;
  logic [G_BITS-1:0] g_resp;

  axi_arbiter #(
    .NUM_M(NUM_M)
  ) arb_i (
    .axi_clk      (axi_clk),
    .axi_resetn   (axi_resetn),
    .g_want       (m_req_valid),
    .req_accepted (s_req_valid && s_req_ready),
    .resp_accepted(s_resp_valid && s_resp_ready),
    .g_req        (g_req),
    .g_resp       (g_resp)
  );

  axil_port_mux #(
    .NUM_M(NUM_M)
  ) mux_i (
    .g_req       (g_req),
    .g_resp      (g_resp),
    .m_req       (m_req),
    .m_req_valid (m_req_valid),
    .m_req_ready (m_req_ready),
    .m_resp      (m_resp),
    .m_resp_valid(m_resp_valid),
    .m_resp_ready(m_resp_ready),
    .s_req       (s_req),
    .s_req_valid (s_req_valid),
    .s_req_ready (s_req_ready),
    .s_resp      (s_resp),
    .s_resp_valid(s_resp_valid),
    .s_resp_ready(s_resp_ready)
  );

  axil_mem #(
    .MEM_WORDS(MEM_WORDS)
  ) mem_i (
    .axi_clk     (axi_clk),
    .axi_resetn  (axi_resetn),
    .s_req       (s_req),
    .s_req_valid (s_req_valid),
    .s_req_ready (s_req_ready),
    .s_resp      (s_resp),
    .s_resp_valid(s_resp_valid),
    .s_resp_ready(s_resp_ready)
  );

endmodule

// File: dv/tb_axil_shared_port.sv
module tb_axil_shared_port
  import axil_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_M     = 3;
  localparam int MEM_WORDS = 256;
  // edges any single wait may take
  localparam int LIMIT     = 4000;

  logic                   axi_clk;
  logic                   axi_resetn;
  axil_req_t  [NUM_M-1:0] m_req;
  logic       [NUM_M-1:0] m_req_valid;
  logic       [NUM_M-1:0] m_req_ready;
  axil_resp_t [NUM_M-1:0] m_resp;
  logic       [NUM_M-1:0] m_resp_valid;
  logic       [NUM_M-1:0] m_resp_ready;

  // reference memory, pending stimulus and expected responses per manager
  logic [DATA_W-1:0] model [MEM_WORDS];
  axil_req_t         stim_q [NUM_M][$];
  axil_resp_t        exp_q [NUM_M][$];
  // manager order of accepted requests and of delivered responses
  int                acc_order [$];
  int                resp_order [$];

  axil_shared_port #(
    .NUM_M    (NUM_M),
    .MEM_WORDS(MEM_WORDS)
  ) dut_i (
    .axi_clk     (axi_clk),
    .axi_resetn  (axi_resetn),
    .m_req       (m_req),
    .m_req_valid (m_req_valid),
    .m_req_ready (m_req_ready),
    .m_resp      (m_resp),
    .m_resp_valid(m_resp_valid),
    .m_resp_ready(m_resp_ready)
  );

  // 8 ns clock
  initial begin
    axi_clk = 1'b0;
    forever #4 axi_clk = ~axi_clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  function automatic axil_req_t make_req(input axil_op_e op, input int word,
                                         input logic [DATA_W-1:0] data,
                                         input logic [STRB_W-1:0] strb);
    axil_req_t r;
    r.op    = op;
    r.addr  = ADDR_W'(word * 4);
    r.wdata = data;
    r.wstrb = strb;
    return r;
  endfunction

  // expected response by the port rules
  // writes also update the model
  function automatic axil_resp_t model_access(input axil_req_t r);
    axil_resp_t resp;
    int         w;
    resp = '0;
    w    = int'(r.addr[ADDR_W-1:2]);
    if (w >= MEM_WORDS) begin
      // out of range so nothing is stored and data stays zero
      resp.err = 1'b1;
    end else if (r.op == OP_READ) begin
      resp.rdata = model[w];
    end else begin
      for (int b = 0; b < STRB_W; b++) begin
        if (r.wstrb[b]) model[w][8*b +: 8] = r.wdata[8*b +: 8];
      end
    end
    return resp;
  endfunction

  // one request into an idle port
  // response valid must rise 3 cycles after request valid
  task automatic single(input int m, input axil_req_t r);
    int n;
    m_req[m]       <= r;
    m_req_valid[m] <= 1'b1;
    exp_q[m].push_back(model_access(r));
    n = 0;
    do begin
      @(posedge axi_clk);
      n++;
      if (n > LIMIT) fail_run("timeout waiting for m_req_ready");
    end while (!m_req_ready[m]);
    m_req_valid[m] <= 1'b0;
    while (!m_resp_valid[m]) begin
      @(posedge axi_clk);
      n++;
      if (n > LIMIT) fail_run("timeout waiting for m_resp_valid");
    end
    // seen one edge after it rose
    assert (n - 1 == 3)
      else fail_run($sformatf("ERR %0t m_resp_valid[%0d] latency got %0d expected 3",
                              $time, m, n - 1));
  endtask

  function automatic bit traffic_done();
    bit done;
    done = (m_req_valid == '0);
    for (int m = 0; m < NUM_M; m++) begin
      if (stim_q[m].size() != 0 || exp_q[m].size() != 0) done = 1'b0;
    end
    return done;
  endfunction

  // all managers drain their stimulus queues back to back
  task automatic run_traffic(input bit stall);
    int        n;
    bit        busy;
    axil_req_t r;
    n = 0;
    while (!traffic_done()) begin
      @(posedge axi_clk);
      n++;
      if (n > LIMIT) fail_run("timeout, traffic did not drain");
      for (int m = 0; m < NUM_M; m++) begin
        busy = m_req_valid[m];
        // handshake on this edge frees the lane
        if (m_req_valid[m] && m_req_ready[m]) begin
          acc_order.push_back(m);
          busy = 1'b0;
        end
        if (!busy && stim_q[m].size() > 0) begin
          r = stim_q[m].pop_front();
          m_req[m]       <= r;
          m_req_valid[m] <= 1'b1;
          exp_q[m].push_back(model_access(r));
        end else if (!busy) begin
          m_req_valid[m] <= 1'b0;
        end
      end
      m_resp_ready <= stall ? NUM_M'($urandom) : '1;
    end
  endtask

  // scoreboard samples mid cycle where valid and ready are settled
  always @(negedge axi_clk) begin
    axil_resp_t want;
    if (axi_resetn) begin
      assert ($onehot0(m_resp_valid))
        else fail_run($sformatf("ERR %0t m_resp_valid got %b expected at most one bit",
                                $time, m_resp_valid));
      for (int m = 0; m < NUM_M; m++) begin
        if (m_resp_valid[m] && m_resp_ready[m]) begin
          assert (exp_q[m].size() > 0)
            else fail_run($sformatf("manager %0d got a response it never asked for", m));
          want = exp_q[m].pop_front();
          assert (m_resp[m] === want)
            else fail_run($sformatf("ERR %0t m_resp[%0d] got %h expected %h",
                                    $time, m, m_resp[m], want));
          resp_order.push_back(m);
        end
      end
    end
  end

  initial begin
    void'($urandom(32'h3dc));
    axi_resetn   <= 1'b0;
    m_req        <= '0;
    m_req_valid  <= '0;
    m_resp_ready <= '1;
    repeat (16) @(posedge axi_clk);
    axi_resetn <= 1'b1;
    @(posedge axi_clk);
    // port quiet after reset
    assert (m_req_ready == '0)
      else fail_run($sformatf("ERR %0t m_req_ready got %b expected 000", $time, m_req_ready));
    assert (m_resp_valid == '0)
      else fail_run($sformatf("ERR %0t m_resp_valid got %b expected 000", $time, m_resp_valid));
    // each manager owns words m*64 up to m*64+7
    // all of them are filled before the directed accesses
    for (int m = 0; m < NUM_M; m++) begin
      for (int k = 0; k < 8; k++) begin
        stim_q[m].push_back(make_req(OP_WRITE, m * 64 + k, $urandom, '1));
      end
    end
    run_traffic(1'b0);
    single(0, make_req(OP_READ, 0, '0, '0));
    // full then partial strobe writes with a read back after each
    single(1, make_req(OP_WRITE, 67, $urandom, 4'hf));
    single(1, make_req(OP_READ, 67, '0, '0));
    single(1, make_req(OP_WRITE, 67, $urandom, 4'b0110));
    single(1, make_req(OP_READ, 67, '0, '0));
    single(1, make_req(OP_WRITE, 67, $urandom, 4'b1001));
    single(1, make_req(OP_READ, 67, '0, '0));
    // word 261 is out of range and aliases word 5 in the array
    single(0, make_req(OP_WRITE, MEM_WORDS + 5, $urandom, 4'hf));
    single(0, make_req(OP_READ, MEM_WORDS + 5, '0, '0));
    single(0, make_req(OP_READ, 5, '0, '0));
    // all three managers raise a request on the same edge
    acc_order.delete();
    resp_order.delete();
    for (int m = 0; m < NUM_M; m++) begin
      stim_q[m].push_back(make_req(OP_READ, m * 64, '0, '0));
    end
    run_traffic(1'b0);
    assert (acc_order.size() == 3 && acc_order[0] == 0 && acc_order[1] == 1 && acc_order[2] == 2)
      else fail_run("requests were not accepted in the order manager 0, 1, 2");
    assert (resp_order.size() == 3 && resp_order[0] == 0 && resp_order[1] == 1 &&
            resp_order[2] == 2)
      else fail_run("responses did not arrive in the order manager 0, 1, 2");
    // random traffic with response back-pressure
    for (int m = 0; m < NUM_M; m++) begin
      for (int k = 0; k < 24; k++) begin
        stim_q[m].push_back(make_req(($urandom % 2 == 0) ? OP_READ : OP_WRITE,
                                     m * 64 + int'($urandom % 8), $urandom,
                                     STRB_W'($urandom)));
      end
    end
    run_traffic(1'b1);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: tb.f
hw/axil_pkg.sv
hw/sync_fifo.sv
hw/axi_arbiter.sv
hw/axil_port_mux.sv
hw/axil_mem.sv
hw/axil_shared_port.sv
dv/tb_axil_shared_port.sv

// File: run.sh
#!/bin/sh
# build and run with Verilator, the simulation log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module tb_axil_shared_port \
  -f tb.f -o tb_sim && ./obj_dir/tb_sim > sim.log 2>&1 || echo "build or simulation error"
cat sim.log 2>/dev/null
grep -qs "SIMULATION FAILED" sim.log && exit 1
grep -qs "SIMULATION PASSED" sim.log || exit 1
exit 0
